// File: include/cl_shell_cfg.svh
`ifndef CL_SHELL_CFG_SVH
`define CL_SHELL_CFG_SVH

// ocl bus widths
`define CL_AXIL_ADDR_W 32
`define CL_AXIL_DATA_W 32
`define CL_AXIL_STRB_W 4

// virtual dip and led width
`define CL_STATUS_W 16

// shell id words
`define CL_SH_ID0_VAL 32'hF000_1D0F
`define CL_SH_ID1_VAL 32'h1D51_FEDC

`define CL_VLED_PATTERN 16'hBEEF

// --------------------------------------------------
// register offsets
// --------------------------------------------------
`define CL_REG_ID0        32'h0000_0000
`define CL_REG_ID1        32'h0000_0004
`define CL_REG_VDIP       32'h0000_0008
`define CL_REG_CYCLES     32'h0000_000C
`define CL_REG_PRINT_STAT 32'h0000_0010
`define CL_REG_SCRATCH    32'h0000_0014

`endif

// File: design/cl_shell_pkg.sv
`include "cl_shell_cfg.svh"

package cl_shell_pkg;

  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic {
    OCL_READ  = 1'b0,
    OCL_WRITE = 1'b1
  } ocl_op_e;

  // --------------------------------------------------
  // axi-lite channel payloads
  // --------------------------------------------------
  typedef struct packed {
    logic [`CL_AXIL_ADDR_W-1:0] addr;
  } axil_aw_s;

  typedef struct packed {
    logic [`CL_AXIL_DATA_W-1:0] data;
    logic [`CL_AXIL_STRB_W-1:0] strb;
  } axil_w_s;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_s;

  typedef struct packed {
    logic [`CL_AXIL_ADDR_W-1:0] addr;
  } axil_ar_s;

  typedef struct packed {
    logic [`CL_AXIL_DATA_W-1:0] data;
    axil_resp_e                 resp;
  } axil_r_s;

  // register access between join, regfile and split
  typedef struct packed {
    ocl_op_e                    op;
    logic [`CL_AXIL_ADDR_W-1:0] addr;
    logic [`CL_AXIL_DATA_W-1:0] data;
    logic [`CL_AXIL_STRB_W-1:0] strb;
  } ocl_req_s;

  typedef struct packed {
    ocl_op_e                    op;
    logic [`CL_AXIL_DATA_W-1:0] data;
    axil_resp_e                 resp;
  } ocl_rsp_s;

endpackage

// File: design/axil_reg_slice.sv
`timescale 1ns/1ps
`include "cl_shell_cfg.svh"

module axil_reg_slice
  import cl_shell_pkg::*;
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  // host side
  input  axil_aw_s s_aw_i,
  input  logic     s_awvalid_i,
  output logic     s_awready_o,
  input  axil_w_s  s_w_i,
  input  logic     s_wvalid_i,
  output logic     s_wready_o,
  output axil_b_s  s_b_o,
  output logic     s_bvalid_o,
  input  logic     s_bready_i,
  input  axil_ar_s s_ar_i,
  input  logic     s_arvalid_i,
  output logic     s_arready_o,
  output axil_r_s  s_r_o,
  output logic     s_rvalid_o,
  input  logic     s_rready_i,
  // core side
  output axil_aw_s m_aw_o,
  output logic     m_awvalid_o,
  input  logic     m_awready_i,
  output axil_w_s  m_w_o,
  output logic     m_wvalid_o,
  input  logic     m_wready_i,
  input  axil_b_s  m_b_i,
  input  logic     m_bvalid_i,
  output logic     m_bready_o,
  output axil_ar_s m_ar_o,
  output logic     m_arvalid_o,
  input  logic     m_arready_i,
  input  axil_r_s  m_r_i,
  input  logic     m_rvalid_i,
  output logic     m_rready_o
);

  localparam int NCH = 5;
  // widest payload is the W channel
  localparam int PW = `CL_AXIL_DATA_W + `CL_AXIL_STRB_W;
  localparam int CH_AW = 0;
  localparam int CH_W = 1;
  localparam int CH_AR = 2;
  localparam int CH_B = 3;
  localparam int CH_R = 4;

  logic [NCH-1:0] in_valid;
  logic [NCH-1:0] in_ready;
  logic [NCH-1:0] out_valid;
  logic [NCH-1:0] out_ready;
  logic [PW-1:0]  in_data  [NCH];
  logic [PW-1:0]  out_data [NCH];

  // --------------------------------------------------
  // channel mapping, payloads zero-extended to PW
  // --------------------------------------------------
  assign in_data[CH_AW] = PW'(s_aw_i);
  assign in_data[CH_W]  = PW'(s_w_i);
  assign in_data[CH_AR] = PW'(s_ar_i);
  assign in_data[CH_B]  = PW'(m_b_i);
  assign in_data[CH_R]  = PW'(m_r_i);

  assign in_valid  = {m_rvalid_i, m_bvalid_i, s_arvalid_i, s_wvalid_i, s_awvalid_i};
  assign out_ready = {s_rready_i, s_bready_i, m_arready_i, m_wready_i, m_awready_i};

  assign s_awready_o = in_ready[CH_AW];
  assign s_wready_o  = in_ready[CH_W];
  assign s_arready_o = in_ready[CH_AR];
  assign m_bready_o  = in_ready[CH_B];
  assign m_rready_o  = in_ready[CH_R];

  assign m_aw_o = axil_aw_s'(out_data[CH_AW][$bits(axil_aw_s)-1:0]);
  assign m_w_o  = axil_w_s'(out_data[CH_W][$bits(axil_w_s)-1:0]);
  assign m_ar_o = axil_ar_s'(out_data[CH_AR][$bits(axil_ar_s)-1:0]);
  assign s_b_o  = axil_b_s'(out_data[CH_B][$bits(axil_b_s)-1:0]);
  assign s_r_o  = axil_r_s'(out_data[CH_R][$bits(axil_r_s)-1:0]);

  assign m_awvalid_o = out_valid[CH_AW];
  assign m_wvalid_o  = out_valid[CH_W];
  assign m_arvalid_o = out_valid[CH_AR];
  assign s_bvalid_o  = out_valid[CH_B];
  assign s_rvalid_o  = out_valid[CH_R];

  // --------------------------------------------------
  // two-entry buffer per channel
  // --------------------------------------------------
  for (genvar ch = 0; ch < NCH; ch++) begin : g_ch
    logic [PW-1:0] mem_q [2];
    logic          wr_ptr_q;
    logic          rd_ptr_q;
    logic [1:0]    cnt_q;
    logic          push;
    logic          pop;

    assign push = in_valid[ch] && in_ready[ch];
    assign pop  = out_valid[ch] && out_ready[ch];

    // ready comes from a flop only, so no path through to the far side
    assign in_ready[ch]  = (cnt_q != 2'd2);
    assign out_valid[ch] = (cnt_q != 2'd0);
    assign out_data[ch]  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
        wr_ptr_q <= 1'b0;
        rd_ptr_q <= 1'b0;
        cnt_q    <= 2'd0;
      end else begin
        if (push) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (pop) begin
          rd_ptr_q <= ~rd_ptr_q;
        end
        cnt_q <= cnt_q + 2'(push) - 2'(pop);
      end
    end

    always_ff @(posedge clk_main_a0) begin
      if (push) begin
        mem_q[wr_ptr_q] <= in_data[ch];
      end
    end

    a_out_stable : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      out_valid[ch] && !out_ready[ch] |=> out_valid[ch] && $stable(out_data[ch]));
  end

endmodule

// File: design/ocl_req_join.sv
`timescale 1ns/1ps

module ocl_req_join
  import cl_shell_pkg::*;
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  input  axil_aw_s aw_i,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  axil_w_s  w_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  axil_ar_s ar_i,
  input  logic     arvalid_i,
  output logic     arready_o,
  output ocl_req_s req_o,
  output logic     req_valid_o,
  input  logic     req_ready_i
);

  ocl_req_s req_q;
  logic     req_valid_q;
  logic     load;
  logic     take_rd;
  logic     take_wr;

  // output slot is free or being accepted this cycle
  assign load = !req_valid_q || req_ready_i;

  // reads win; a write needs address and data together
  assign take_rd = load && arvalid_i;
  assign take_wr = load && !arvalid_i && awvalid_i && wvalid_i;

  assign arready_o = take_rd;
  assign awready_o = take_wr;
  assign wready_o  = take_wr;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      req_valid_q <= 1'b0;
    end else if (load) begin
      req_valid_q <= take_rd || take_wr;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (take_rd) begin
      req_q <= '{op: OCL_READ, addr: ar_i.addr, data: '0, strb: '0};
    end else if (take_wr) begin
      req_q <= '{op: OCL_WRITE, addr: aw_i.addr, data: w_i.data, strb: w_i.strb};
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  a_req_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

// File: design/ocl_regfile.sv
`timescale 1ns/1ps
`include "cl_shell_cfg.svh"

module ocl_regfile
  import cl_shell_pkg::*;
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  ocl_req_s                   req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output ocl_rsp_s                   rsp_o,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  input  logic [`CL_STATUS_W-1:0]    vdip_sync_i,
  output logic                       print_stat_v_o,
  output logic [`CL_AXIL_DATA_W-1:0] print_stat_tag_o
);

  logic [`CL_AXIL_DATA_W-1:0] cycles_q;
  logic [`CL_AXIL_DATA_W-1:0] scratch_q;
  logic [`CL_AXIL_DATA_W-1:0] tag_q;
  logic [`CL_AXIL_DATA_W-1:0] rd_data;
  logic                       hit;
  logic                       req_fire;
  logic                       is_wr;
  logic                       wr_scratch;
  logic                       wr_print;
  logic                       print_v_q;
  logic                       rsp_valid_q;
  ocl_rsp_s                   rsp_q;

  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign is_wr       = (req_i.op == OCL_WRITE);
  assign wr_scratch  = req_fire && is_wr && (req_i.addr == `CL_REG_SCRATCH);
  assign wr_print    = req_fire && is_wr && (req_i.addr == `CL_REG_PRINT_STAT);

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    case (req_i.addr)
      `CL_REG_ID0:        rd_data = `CL_SH_ID0_VAL;
      `CL_REG_ID1:        rd_data = `CL_SH_ID1_VAL;
      `CL_REG_VDIP:       rd_data = `CL_AXIL_DATA_W'(vdip_sync_i);
      `CL_REG_CYCLES:     rd_data = cycles_q;
      `CL_REG_PRINT_STAT: rd_data = tag_q;
      `CL_REG_SCRATCH:    rd_data = scratch_q;
      default:            hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cycles_q    <= '0;
      scratch_q   <= '0;
      tag_q       <= '0;
      print_v_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      cycles_q  <= cycles_q + 1'b1;
      // one-cycle strobe per print-stat write
      print_v_q <= wr_print;
      if (wr_print) begin
        tag_q <= req_i.data;
      end
      if (wr_scratch) begin
        for (int b = 0; b < `CL_AXIL_STRB_W; b++) begin
          if (req_i.strb[b]) begin
            scratch_q[8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end
      if (req_ready_o) begin
        rsp_valid_q <= req_valid_i;
      end
    end
  end

  // response payload, read data zero on writes and misses
  always_ff @(posedge clk_main_a0) begin
    if (req_fire) begin
      rsp_q.op   <= req_i.op;
      rsp_q.data <= is_wr ? '0 : rd_data;
      rsp_q.resp <= hit ? AXIL_OKAY : AXIL_SLVERR;
    end
  end

  assign rsp_o            = rsp_q;
  assign rsp_valid_o      = rsp_valid_q;
  assign print_stat_v_o   = print_v_q;
  assign print_stat_tag_o = tag_q;

endmodule

// File: design/ocl_rsp_split.sv
`timescale 1ns/1ps

module ocl_rsp_split
  import cl_shell_pkg::*;
(
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  input  ocl_rsp_s rsp_i,
  input  logic     rsp_valid_i,
  output logic     rsp_ready_o,
  output axil_b_s  b_o,
  output logic     bvalid_o,
  input  logic     bready_i,
  output axil_r_s  r_o,
  output logic     rvalid_o,
  input  logic     rready_i
);

  ocl_rsp_s rsp_q;
  logic     valid_q;
  logic     drain;

  // opcode picks the channel
  assign bvalid_o = valid_q && (rsp_q.op == OCL_WRITE);
  assign rvalid_o = valid_q && (rsp_q.op == OCL_READ);

  assign drain       = (bvalid_o && bready_i) || (rvalid_o && rready_i);
  assign rsp_ready_o = !valid_q || drain;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      valid_q <= 1'b0;
    end else if (rsp_ready_o) begin
      valid_q <= rsp_valid_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (rsp_valid_i && rsp_ready_o) begin
      rsp_q <= rsp_i;
    end
  end

  assign b_o.resp = rsp_q.resp;
  assign r_o.data = rsp_q.data;
  assign r_o.resp = rsp_q.resp;

  a_one_channel : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(bvalid_o && rvalid_o));

endmodule

// File: design/shell_status.sv
`timescale 1ns/1ps
`include "cl_shell_cfg.svh"

module shell_status (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  logic [`CL_STATUS_W-1:0] sh_cl_status_vdip_i,
  output logic [`CL_STATUS_W-1:0] vdip_sync_o,
  output logic [`CL_STATUS_W-1:0] cl_sh_status_vled_o
);

  logic [`CL_STATUS_W-1:0] vdip_q;
  logic [`CL_STATUS_W-1:0] vdip_q2;
  logic [`CL_STATUS_W-1:0] vled_q;
  logic [`CL_STATUS_W-1:0] vled_out_q;

  // dip: two flops in from the shell
  // led: pattern reaches the pin two cycles out of reset
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q     <= '0;
      vdip_q2    <= '0;
      vled_q     <= '0;
      vled_out_q <= '0;
    end else begin
      vdip_q     <= sh_cl_status_vdip_i;
      vdip_q2    <= vdip_q;
      vled_q     <= `CL_VLED_PATTERN;
      vled_out_q <= vled_q;
    end
  end

  assign vdip_sync_o         = vdip_q2;
  assign cl_sh_status_vled_o = vled_out_q;

endmodule

// File: design/cl_shell_lite.sv
`timescale 1ns/1ps
`include "cl_shell_cfg.svh"

module cl_shell_lite
  import cl_shell_pkg::*;
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  // ocl host channels
  input  axil_aw_s                   sh_ocl_aw_i,
  input  logic                       sh_ocl_awvalid_i,
  output logic                       ocl_sh_awready_o,
  input  axil_w_s                    sh_ocl_w_i,
  input  logic                       sh_ocl_wvalid_i,
  output logic                       ocl_sh_wready_o,
  output axil_b_s                    ocl_sh_b_o,
  output logic                       ocl_sh_bvalid_o,
  input  logic                       sh_ocl_bready_i,
  input  axil_ar_s                   sh_ocl_ar_i,
  input  logic                       sh_ocl_arvalid_i,
  output logic                       ocl_sh_arready_o,
  output axil_r_s                    ocl_sh_r_o,
  output logic                       ocl_sh_rvalid_o,
  input  logic                       sh_ocl_rready_i,
  // shell status
  input  logic [`CL_STATUS_W-1:0]    sh_cl_status_vdip_i,
  output logic [`CL_STATUS_W-1:0]    cl_sh_status_vled_o,
  output logic [31:0]                cl_sh_id0_o,
  output logic [31:0]                cl_sh_id1_o,
  output logic                       print_stat_v_o,
  output logic [`CL_AXIL_DATA_W-1:0] print_stat_tag_o
);

  // --------------------------------------------------
  // slice to core wires
  // --------------------------------------------------
  axil_aw_s m_aw;
  logic     m_awvalid;
  logic     m_awready;
  axil_w_s  m_w;
  logic     m_wvalid;
  logic     m_wready;
  axil_b_s  m_b;
  logic     m_bvalid;
  logic     m_bready;
  axil_ar_s m_ar;
  logic     m_arvalid;
  logic     m_arready;
  axil_r_s  m_r;
  logic     m_rvalid;
  logic     m_rready;

  ocl_req_s                req;
  logic                    req_valid;
  logic                    req_ready;
  ocl_rsp_s                rsp;
  logic                    rsp_valid;
  logic                    rsp_ready;
  logic [`CL_STATUS_W-1:0] vdip_sync;

  assign cl_sh_id0_o = `CL_SH_ID0_VAL;
  assign cl_sh_id1_o = `CL_SH_ID1_VAL;

  axil_reg_slice axil_reg_slice_i (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .s_aw_i         (sh_ocl_aw_i),
    .s_awvalid_i    (sh_ocl_awvalid_i),
    .s_awready_o    (ocl_sh_awready_o),
    .s_w_i          (sh_ocl_w_i),
    .s_wvalid_i     (sh_ocl_wvalid_i),
    .s_wready_o     (ocl_sh_wready_o),
    .s_b_o          (ocl_sh_b_o),
    .s_bvalid_o     (ocl_sh_bvalid_o),
    .s_bready_i     (sh_ocl_bready_i),
    .s_ar_i         (sh_ocl_ar_i),
    .s_arvalid_i    (sh_ocl_arvalid_i),
    .s_arready_o    (ocl_sh_arready_o),
    .s_r_o          (ocl_sh_r_o),
    .s_rvalid_o     (ocl_sh_rvalid_o),
    .s_rready_i     (sh_ocl_rready_i),
    .m_aw_o         (m_aw),
    .m_awvalid_o    (m_awvalid),
    .m_awready_i    (m_awready),
    .m_w_o          (m_w),
    .m_wvalid_o     (m_wvalid),
    .m_wready_i     (m_wready),
    .m_b_i          (m_b),
    .m_bvalid_i     (m_bvalid),
    .m_bready_o     (m_bready),
    .m_ar_o         (m_ar),
    .m_arvalid_o    (m_arvalid),
    .m_arready_i    (m_arready),
    .m_r_i          (m_r),
    .m_rvalid_i     (m_rvalid),
    .m_rready_o     (m_rready)
  );

  ocl_req_join ocl_req_join_i (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .aw_i           (m_aw),
    .awvalid_i      (m_awvalid),
    .awready_o      (m_awready),
    .w_i            (m_w),
    .wvalid_i       (m_wvalid),
    .wready_o       (m_wready),
    .ar_i           (m_ar),
    .arvalid_i      (m_arvalid),
    .arready_o      (m_arready),
    .req_o          (req),
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready)
  );

  ocl_regfile ocl_regfile_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .rsp_o           (rsp),
    .rsp_valid_o     (rsp_valid),
    .rsp_ready_i     (rsp_ready),
    .vdip_sync_i     (vdip_sync),
    .print_stat_v_o  (print_stat_v_o),
    .print_stat_tag_o(print_stat_tag_o)
  );

  ocl_rsp_split ocl_rsp_split_i (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .rsp_i          (rsp),
    .rsp_valid_i    (rsp_valid),
    .rsp_ready_o    (rsp_ready),
    .b_o            (m_b),
    .bvalid_o       (m_bvalid),
    .bready_i       (m_bready),
    .r_o            (m_r),
    .rvalid_o       (m_rvalid),
    .rready_i       (m_rready)
  );

  shell_status shell_status_i (
    .clk_main_a0        (clk_main_a0),
    .rst_main_n_sync    (rst_main_n_sync),
    .sh_cl_status_vdip_i(sh_cl_status_vdip_i),
    .vdip_sync_o        (vdip_sync),
    .cl_sh_status_vled_o(cl_sh_status_vled_o)
  );

endmodule

// File: tb/tb_cl_shell_lite.sv
`timescale 1ns/1ps
`include "cl_shell_cfg.svh"

module tb_cl_shell_lite
  import cl_shell_pkg::*;
();

  // the directed tests take well under a thousand cycles
  localparam int MAX_CYCLES = 5000;
  localparam int BP_READS = 8;

  logic                    clk_main_a0;
  logic                    rst_main_n_sync;
  axil_aw_s                aw;
  logic                    awvalid;
  logic                    awready;
  axil_w_s                 w;
  logic                    wvalid;
  logic                    wready;
  axil_b_s                 b;
  logic                    bvalid;
  logic                    bready;
  axil_ar_s                ar;
  logic                    arvalid;
  logic                    arready;
  axil_r_s                 r;
  logic                    rvalid;
  logic                    rready;
  logic [`CL_STATUS_W-1:0] vdip;
  logic [`CL_STATUS_W-1:0] vled;
  logic [31:0]             id0;
  logic [31:0]             id1;
  logic                    print_v;
  logic [31:0]             print_tag;

  integer                  seed = 88735;
  int                      err_count = 0;
  int                      test_count = 0;
  int                      test_err_start = 0;
  int                      cycle_count = 0;
  int                      pulse_count = 0;
  string                   cur_test = "none";
  logic [31:0]             pulse_tag = '0;
  logic [31:0]             scratch_exp = '0;
  logic [15:0]             dip_val = '0;
  logic                    stall_seen = 1'b0;

  cl_shell_lite cl_shell_lite_i (
    .clk_main_a0        (clk_main_a0),
    .rst_main_n_sync    (rst_main_n_sync),
    .sh_ocl_aw_i        (aw),
    .sh_ocl_awvalid_i   (awvalid),
    .ocl_sh_awready_o   (awready),
    .sh_ocl_w_i         (w),
    .sh_ocl_wvalid_i    (wvalid),
    .ocl_sh_wready_o    (wready),
    .ocl_sh_b_o         (b),
    .ocl_sh_bvalid_o    (bvalid),
    .sh_ocl_bready_i    (bready),
    .sh_ocl_ar_i        (ar),
    .sh_ocl_arvalid_i   (arvalid),
    .ocl_sh_arready_o   (arready),
    .ocl_sh_r_o         (r),
    .ocl_sh_rvalid_o    (rvalid),
    .sh_ocl_rready_i    (rready),
    .sh_cl_status_vdip_i(vdip),
    .cl_sh_status_vled_o(vled),
    .cl_sh_id0_o        (id0),
    .cl_sh_id1_o        (id1),
    .print_stat_v_o     (print_v),
    .print_stat_tag_o   (print_tag)
  );

  always #10 clk_main_a0 = ~clk_main_a0;

  always @(posedge clk_main_a0) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles, test %s", MAX_CYCLES, cur_test);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // print-stat strobe is a flop output, steady at the falling edge
  always @(negedge clk_main_a0) begin
    if (print_v) begin
      pulse_count = pulse_count + 1;
      pulse_tag = print_tag;
    end
  end

  // --------------------------------------------------
  // bookkeeping and checks
  // --------------------------------------------------
  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = err_count;
  endtask

  task automatic end_test();
    test_count = test_count + 1;
    $display("test %-14s %s", cur_test, (err_count == test_err_start) ? "passed" : "failed");
  endtask

  task automatic check_val(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      err_count = err_count + 1;
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, expected, actual);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // register map as the host sees it
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    case (addr)
      `CL_REG_ID0:     return `CL_SH_ID0_VAL;
      `CL_REG_ID1:     return `CL_SH_ID1_VAL;
      `CL_REG_SCRATCH: return scratch_exp;
      `CL_REG_VDIP:    return {16'd0, dip_val};
      default:         return 32'd0;
    endcase
  endfunction

  // --------------------------------------------------
  // axi-lite host driver
  // --------------------------------------------------
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    logic aw_pend;
    logic w_pend;
    logic aw_go;
    logic w_go;
    @(negedge clk_main_a0);
    aw.addr = addr;
    awvalid = 1'b1;
    w.data = data;
    w.strb = strb;
    wvalid = 1'b1;
    aw_pend = 1'b1;
    w_pend = 1'b1;
    while (aw_pend || w_pend) begin
      // readies come from flops and hold through the low phase
      aw_go = aw_pend && awready;
      w_go = w_pend && wready;
      @(negedge clk_main_a0);
      if (aw_go) begin
        awvalid = 1'b0;
        aw_pend = 1'b0;
      end
      if (w_go) begin
        wvalid = 1'b0;
        w_pend = 1'b0;
      end
    end
    while (!bvalid) begin
      @(negedge clk_main_a0);
    end
    resp = b.resp;
    @(negedge clk_main_a0);
  endtask

  task automatic issue_read(input logic [31:0] addr);
    logic go;
    @(negedge clk_main_a0);
    ar.addr = addr;
    arvalid = 1'b1;
    go = 1'b0;
    while (!go) begin
      go = arready;
      if (!go) begin
        stall_seen = 1'b1;
      end
      @(negedge clk_main_a0);
    end
    arvalid = 1'b0;
  endtask

  task automatic collect_read(output logic [31:0] data, output logic [1:0] resp);
    while (!rvalid) begin
      @(negedge clk_main_a0);
    end
    data = r.data;
    resp = r.resp;
    // rready is high, so the beat leaves at the next rising edge
    @(negedge clk_main_a0);
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    issue_read(addr);
    collect_read(data, resp);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    start_test("reset_state");
    repeat (9) @(negedge clk_main_a0);
    check_val("led in reset", 32'd0, 32'(vled));
    check_val("bvalid in reset", 32'd0, 32'(bvalid));
    check_val("rvalid in reset", 32'd0, 32'(rvalid));
    check_val("print_stat_v in reset", 32'd0, 32'(print_v));
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    repeat (3) @(negedge clk_main_a0);
    check_val("led after reset", 32'(`CL_VLED_PATTERN), 32'(vled));
    check_val("id0 output", `CL_SH_ID0_VAL, id0);
    check_val("id1 output", `CL_SH_ID1_VAL, id1);
    check_val("print_stat_v after reset", 32'd0, 32'(print_v));
    end_test();
  endtask

  task automatic test_id_dip();
    logic [31:0] data;
    logic [1:0]  resp;
    start_test("id_dip");
    axil_read(`CL_REG_ID0, data, resp);
    check_val("id0 data", `CL_SH_ID0_VAL, data);
    check_val("id0 resp", 32'(AXIL_OKAY), 32'(resp));
    axil_read(`CL_REG_ID1, data, resp);
    check_val("id1 data", `CL_SH_ID1_VAL, data);
    check_val("id1 resp", 32'(AXIL_OKAY), 32'(resp));
    @(negedge clk_main_a0);
    dip_val = 16'($random(seed));
    vdip = dip_val;
    repeat (5) @(negedge clk_main_a0);
    axil_read(`CL_REG_VDIP, data, resp);
    check_val("dip data", {16'd0, dip_val}, data);
    check_val("dip resp", 32'(AXIL_OKAY), 32'(resp));
    end_test();
  endtask

  task automatic test_scratch();
    logic [31:0] wdata;
    logic [31:0] data;
    logic [1:0]  resp;
    start_test("scratch");
    wdata = $random(seed);
    axil_write(`CL_REG_SCRATCH, wdata, 4'hF, resp);
    check_val("full write resp", 32'(AXIL_OKAY), 32'(resp));
    scratch_exp = wdata;
    axil_read(`CL_REG_SCRATCH, data, resp);
    check_val("full write readback", scratch_exp, data);
    wdata = $random(seed);
    axil_write(`CL_REG_SCRATCH, wdata, 4'b0101, resp);
    scratch_exp = merge_bytes(scratch_exp, wdata, 4'b0101);
    axil_read(`CL_REG_SCRATCH, data, resp);
    check_val("partial write readback", scratch_exp, data);
    // id0 is read-only, the write is dropped
    axil_write(`CL_REG_ID0, $random(seed), 4'hF, resp);
    check_val("id0 write resp", 32'(AXIL_OKAY), 32'(resp));
    axil_read(`CL_REG_ID0, data, resp);
    check_val("id0 after write", `CL_SH_ID0_VAL, data);
    end_test();
  endtask

  task automatic test_print_stat();
    logic [31:0] tag;
    logic [1:0]  resp;
    int          pulses_before;
    start_test("print_stat");
    tag = $random(seed);
    pulses_before = pulse_count;
    axil_write(`CL_REG_PRINT_STAT, tag, 4'hF, resp);
    repeat (6) @(negedge clk_main_a0);
    check_val("strobe cycles", 32'd1, 32'(pulse_count - pulses_before));
    check_val("tag", tag, pulse_tag);
    check_val("resp", 32'(AXIL_OKAY), 32'(resp));
    end_test();
  endtask

  task automatic test_cycles_errors();
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] data;
    logic [1:0]  resp;
    start_test("cycles_errors");
    axil_read(`CL_REG_CYCLES, c1, resp);
    repeat (50) @(negedge clk_main_a0);
    axil_read(`CL_REG_CYCLES, c2, resp);
    check_val("cycle gap at least 50", 32'd1, {31'd0, (c2 - c1) >= 32'd50});
    axil_read(32'h0000_0100, data, resp);
    check_val("unmapped read resp", 32'(AXIL_SLVERR), 32'(resp));
    check_val("unmapped read data", 32'd0, data);
    axil_write(32'h0000_0200, $random(seed), 4'hF, resp);
    check_val("unmapped write resp", 32'(AXIL_SLVERR), 32'(resp));
    end_test();
  endtask

  // eight reads overfill the seven slots between host AR and host R
  task automatic test_backpressure();
    logic [31:0] addrs    [BP_READS];
    logic [31:0] got_data [BP_READS];
    logic [1:0]  got_resp [BP_READS];
    int          issued;
    start_test("backpressure");
    for (int i = 0; i < BP_READS; i++) begin
      case (i % 4)
        0:       addrs[i] = `CL_REG_ID0;
        1:       addrs[i] = `CL_REG_ID1;
        2:       addrs[i] = `CL_REG_SCRATCH;
        default: addrs[i] = `CL_REG_VDIP;
      endcase
    end
    @(negedge clk_main_a0);
    rready = 1'b0;
    stall_seen = 1'b0;
    issued = 0;
    fork
      begin
        for (int i = 0; i < BP_READS; i++) begin
          issue_read(addrs[i]);
          issued = issued + 1;
        end
      end
      begin
        // rready stays low until arready drops or every read is in
        while (!stall_seen && issued < BP_READS) begin
          @(negedge clk_main_a0);
        end
        repeat (4) @(negedge clk_main_a0);
        rready = 1'b1;
        for (int i = 0; i < BP_READS; i++) begin
          collect_read(got_data[i], got_resp[i]);
        end
      end
    join
    check_val("arready fell", 32'd1, 32'(stall_seen));
    for (int i = 0; i < BP_READS; i++) begin
      check_val($sformatf("read %0d data", i), expected_read(addrs[i]), got_data[i]);
      check_val($sformatf("read %0d resp", i), 32'(AXIL_OKAY), 32'(got_resp[i]));
    end
    end_test();
  endtask

  initial begin
    clk_main_a0 = 1'b0;
    rst_main_n_sync = 1'b0;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    ar = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    vdip = '0;
    test_reset_state();
    test_id_dip();
    test_scratch();
    test_print_stat();
    test_cycles_errors();
    test_backpressure();
    $display("tests run %0d, errors %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
design/cl_shell_pkg.sv
design/axil_reg_slice.sv
design/ocl_req_join.sv
design/ocl_regfile.sv
design/ocl_rsp_split.sv
design/shell_status.sv
design/cl_shell_lite.sv
tb/tb_cl_shell_lite.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f files.f \
  --top-module tb_cl_shell_lite -o tb_cl_shell_lite_sim &&
  ./obj_dir/tb_cl_shell_lite_sim | tee sim.log &&
  grep -q "Simulation finished: PASS" sim.log &&
  echo "run_sim: run passed" ||
  { echo "run_sim: build or run failed"; exit 1; }
